//--- verilog/residuPkg.sv
package residuPkg;

	////////////////////////////////////////////////////////////////////////////
	// Word sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int WordWidth = 16;
	localparam int LongWidth = 32;
	localparam int AddrWidth = 11;
	localparam int CountWidth = 6;

	// Q15 sample or coefficient
	typedef logic signed [WordWidth-1:0] word;
	// Q31 accumulator
	typedef logic signed [LongWidth-1:0] longWord;
	// Scratch memory address, wraps at the top
	typedef logic [AddrWidth-1:0] addr;

	////////////////////////////////////////////////////////////////////////////
	// Filter constants
	////////////////////////////////////////////////////////////////////////////

	// Highest coefficient index a[10]
	localparam int FilterOrder = 10;
	localparam int ShiftCount = 3;

	localparam longWord MaxLong = 32'sh7FFF_FFFF;
	localparam longWord MinLong = 32'sh8000_0000;
	// Added before the upper word is taken
	localparam longWord RoundConst = 32'sh0000_8000;

	// What the multiply-accumulate unit computes
	typedef enum logic [1:0]
	{
		opMult,
		opMac,
		opRound
	} macOp;

endpackage

//--- verilog/scratchRam.sv
`timescale 1ns/1ps

module scratchRam
#(
	parameter int Depth = 2 ** residuPkg::AddrWidth
)
(
	input  logic           clk,
	input  residuPkg::addr readAddr1,
	input  residuPkg::addr readAddr2,
	input  residuPkg::addr writeAddr,
	input  logic           writeEn,
	input  residuPkg::word writeData,
	output residuPkg::word readData1,
	output residuPkg::word readData2
);

	// Coefficients, inputs and outputs all share this array
	residuPkg::word mem [Depth];

	////////////////////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (writeEn)
			mem[writeAddr] <= writeData;
	end

	////////////////////////////////////////////////////////////////////////////
	// Read ports, one cycle of latency
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		readData1 <= mem[readAddr1];
	end

	always_ff @(posedge clk)
	begin
		readData2 <= mem[readAddr2];
	end

endmodule

//--- verilog/macUnit.sv
`timescale 1ns/1ps

module macUnit
(
	input  residuPkg::macOp    sel,
	input  residuPkg::word     a,
	input  residuPkg::word     b,
	input  residuPkg::longWord acc,
	output residuPkg::longWord result
);

	logic signed [31:0] product;
	residuPkg::longWord multSat;

	// 32-bit add clipped to the long range
	function automatic residuPkg::longWord satAdd
	(
		input residuPkg::longWord x,
		input residuPkg::longWord y
	);
		logic signed [32:0] sum;
		sum = {x[31], x} + {y[31], y};
		if (sum[32] != sum[31])
			return sum[32] ? residuPkg::MinLong : residuPkg::MaxLong;
		return sum[31:0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Fractional multiply
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		product = a * b;
		// Only -1.0 times -1.0 can overflow once doubled
		if (product == 32'sh4000_0000)
			multSat = residuPkg::MaxLong;
		else
			multSat = product <<< 1;
	end

	always_comb
	begin
		case (sel)
			residuPkg::opMult:
				result = multSat;
			residuPkg::opMac:
				result = satAdd(acc, multSat);
			residuPkg::opRound:
				result = satAdd(acc, residuPkg::RoundConst);
			default:
				result = multSat;
		endcase
	end

endmodule

//--- verilog/longShifter.sv
`timescale 1ns/1ps

module longShifter
#(
	parameter int ShiftCount = residuPkg::ShiftCount
)
(
	input  logic               clk,
	input  logic               reset,
	input  logic               go,
	input  residuPkg::longWord value,
	output residuPkg::longWord result,
	output logic               done
);

	localparam int CountWidth = $clog2(ShiftCount + 2);

	logic active;
	logic [CountWidth-1:0] stepCount;
	residuPkg::longWord shiftReg;

	// Doubling, pinned at the rails once the sign would flip
	function automatic residuPkg::longWord satDouble(input residuPkg::longWord v);
		if (v[31] != v[30])
			return v[31] ? residuPkg::MinLong : residuPkg::MaxLong;
		return v <<< 1;
	endfunction

	// First step is taken as the value is loaded
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			active <= 1'b0;
			stepCount <= '0;
		end
		else if (go)
		begin
			active <= 1'b1;
			stepCount <= CountWidth'(ShiftCount > 0 ? 1 : 0);
		end
		else if (done)
			active <= 1'b0;
		else if (active)
			stepCount <= stepCount + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (go)
			shiftReg <= (ShiftCount > 0) ? satDouble(value) : value;
		else if (active && !done)
			shiftReg <= satDouble(shiftReg);
	end

	assign done = active && (stepCount == CountWidth'(ShiftCount));
	assign result = shiftReg;

endmodule

//--- verilog/residuFsm.sv
`timescale 1ns/1ps

module residuFsm
(
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 start,
	input  residuPkg::addr                       baseA,
	input  residuPkg::addr                       baseX,
	input  residuPkg::addr                       baseY,
	input  logic [residuPkg::CountWidth-1:0]     count,
	input  residuPkg::word                       readData1,
	input  residuPkg::word                       readData2,
	input  residuPkg::longWord                   macResult,
	input  residuPkg::longWord                   shiftOut,
	input  logic                                 shiftDone,
	output logic                                 done,
	output logic                                 busy,
	output residuPkg::addr                       readAddr1,
	output residuPkg::addr                       readAddr2,
	output logic                                 writeEn,
	output residuPkg::addr                       writeAddr,
	output residuPkg::word                       writeData,
	output residuPkg::macOp                      macSel,
	output residuPkg::word                       macA,
	output residuPkg::word                       macB,
	output residuPkg::longWord                   macAcc,
	output logic                                 shiftGo,
	output residuPkg::longWord                   shiftIn
);

	typedef enum logic [3:0]
	{
		sIdle,
		sOuter,
		sFetch,
		sMult,
		sInner,
		sTapRead,
		sMac,
		sShiftGo,
		sShiftWait,
		sRound,
		sDone
	} stateType;

	stateType state;
	stateType nextState;

	// Sample index i and tap index j
	logic [residuPkg::CountWidth-1:0] sampleIdx;
	logic [3:0] tapIdx;

	// Operand from the previous read, and the running sum
	residuPkg::word held;
	residuPkg::longWord acc;

	////////////////////////////////////////////////////////////////////////////
	// Loop counters and state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= sIdle;
			sampleIdx <= '0;
			tapIdx <= 4'd1;
		end
		else
		begin
			state <= nextState;
			case (state)
				sIdle:
					sampleIdx <= '0;
				sMult:
					tapIdx <= 4'd1;
				sMac:
					tapIdx <= tapIdx + 4'd1;
				sRound:
					sampleIdx <= sampleIdx + 1'b1;
				default:
				begin
				end
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge clk)
	begin
		case (state)
			sFetch:
				held <= readData2;
			sTapRead:
				held <= readData1;
			sMult, sMac:
				acc <= macResult;
			sShiftWait:
				if (shiftDone)
					acc <= shiftOut;
			default:
			begin
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Next state and datapath controls
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		done = 1'b0;
		busy = (state != sIdle);
		readAddr1 = '0;
		readAddr2 = '0;
		writeEn = 1'b0;
		writeAddr = '0;
		writeData = '0;
		macSel = residuPkg::opMult;
		macA = '0;
		macB = '0;
		macAcc = '0;
		shiftGo = 1'b0;
		shiftIn = '0;

		case (state)
			sIdle:
				if (start)
					nextState = sOuter;
			sOuter:
				if (sampleIdx < count)
				begin
					// Request x[i]
					readAddr2 = baseX + residuPkg::addr'(sampleIdx);
					nextState = sFetch;
				end
				else
					nextState = sDone;
			sFetch:
			begin
				readAddr1 = baseA;
				nextState = sMult;
			end
			sMult:
			begin
				// x[i] times a[0] starts the sum
				macSel = residuPkg::opMult;
				macA = held;
				macB = readData1;
				nextState = sInner;
			end
			sInner:
				if (tapIdx <= 4'(residuPkg::FilterOrder))
				begin
					readAddr1 = baseA + residuPkg::addr'(tapIdx);
					nextState = sTapRead;
				end
				else
					nextState = sShiftGo;
			sTapRead:
			begin
				// x[i-j], may reach below baseX into the history
				readAddr2 = baseX + residuPkg::addr'(sampleIdx) - residuPkg::addr'(tapIdx);
				nextState = sMac;
			end
			sMac:
			begin
				macSel = residuPkg::opMac;
				macA = held;
				macB = readData2;
				macAcc = acc;
				nextState = sInner;
			end
			sShiftGo:
			begin
				shiftGo = 1'b1;
				shiftIn = acc;
				nextState = sShiftWait;
			end
			sShiftWait:
				if (shiftDone)
					nextState = sRound;
			sRound:
			begin
				macSel = residuPkg::opRound;
				macAcc = acc;
				writeEn = 1'b1;
				writeAddr = baseY + residuPkg::addr'(sampleIdx);
				writeData = macResult[31:16];
				nextState = sOuter;
			end
			sDone:
			begin
				done = 1'b1;
				nextState = sIdle;
			end
			default:
				nextState = sIdle;
		endcase
	end

endmodule

//--- verilog/residuTop.sv
`timescale 1ns/1ps

module residuTop
#(
	parameter int ShiftCount = residuPkg::ShiftCount,
	parameter int Depth = 2 ** residuPkg::AddrWidth
)
(
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             start,
	input  residuPkg::addr                   baseA,
	input  residuPkg::addr                   baseX,
	input  residuPkg::addr                   baseY,
	input  logic [residuPkg::CountWidth-1:0] count,
	input  logic                             hostWriteEn,
	input  residuPkg::addr                   hostAddr,
	input  residuPkg::word                   hostWriteData,
	output logic                             done,
	output logic                             busy,
	output residuPkg::word                   hostReadData
);

	residuPkg::addr fsmReadAddr1, readAddr2, fsmWriteAddr, ramReadAddr1, ramWriteAddr;
	residuPkg::word fsmWriteData, ramWriteData, readData1, readData2;
	logic fsmWriteEn, ramWriteEn;
	residuPkg::macOp macSel;
	residuPkg::word macA, macB;
	residuPkg::longWord macAcc, macResult, shiftIn, shiftOut;
	logic shiftGo, shiftDone;

	// Host owns port 1 and the write port while idle
	assign ramReadAddr1 = busy ? fsmReadAddr1 : hostAddr;
	assign ramWriteAddr = busy ? fsmWriteAddr : hostAddr;
	assign ramWriteData = busy ? fsmWriteData : hostWriteData;
	assign ramWriteEn = busy ? fsmWriteEn : hostWriteEn;
	assign hostReadData = readData1;

	residuFsm fsmInst
	(
		.clk(clk), .reset(reset), .start(start),
		.baseA(baseA), .baseX(baseX), .baseY(baseY), .count(count),
		.readData1(readData1), .readData2(readData2),
		.macResult(macResult), .shiftOut(shiftOut), .shiftDone(shiftDone),
		.done(done), .busy(busy),
		.readAddr1(fsmReadAddr1), .readAddr2(readAddr2),
		.writeEn(fsmWriteEn), .writeAddr(fsmWriteAddr), .writeData(fsmWriteData),
		.macSel(macSel), .macA(macA), .macB(macB), .macAcc(macAcc),
		.shiftGo(shiftGo), .shiftIn(shiftIn)
	);

	macUnit macInst (.sel(macSel), .a(macA), .b(macB), .acc(macAcc), .result(macResult));

	longShifter #(.ShiftCount(ShiftCount)) shifterInst
	(
		.clk(clk), .reset(reset), .go(shiftGo), .value(shiftIn),
		.result(shiftOut), .done(shiftDone)
	);

	scratchRam #(.Depth(Depth)) ramInst
	(
		.clk(clk), .readAddr1(ramReadAddr1), .readAddr2(readAddr2),
		.writeAddr(ramWriteAddr), .writeEn(ramWriteEn), .writeData(ramWriteData),
		.readData1(readData1), .readData2(readData2)
	);

endmodule

//--- verification/residuTb.sv
`timescale 1ns/1ps

module residuTb;

	localparam int MemDepth = 2048;
	localparam int WaitLimit = 4000;

	logic clk;
	logic reset;
	logic start;
	residuPkg::addr baseA;
	residuPkg::addr baseX;
	residuPkg::addr baseY;
	logic [residuPkg::CountWidth-1:0] count;
	logic hostWriteEn;
	residuPkg::addr hostAddr;
	residuPkg::word hostWriteData;
	logic done;
	logic busy;
	residuPkg::word hostReadData;

	// Expected memory contents
	residuPkg::word model [MemDepth];
	int seed = 24346;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int errorsAtStart = 0;

	residuTop #(.ShiftCount(residuPkg::ShiftCount), .Depth(MemDepth)) dut_i
	(
		.clk(clk), .reset(reset), .start(start),
		.baseA(baseA), .baseX(baseX), .baseY(baseY), .count(count),
		.hostWriteEn(hostWriteEn), .hostAddr(hostAddr), .hostWriteData(hostWriteData),
		.done(done), .busy(busy), .hostReadData(hostReadData)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks and bus helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic checkWord(input string what, input residuPkg::word got,
		input residuPkg::word exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkFlag(input string what, input logic got, input logic exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Inputs change 1 ns after the edge
	task automatic nextCycle;
		@(posedge clk);
		#1;
	endtask

	task automatic hostWrite(input residuPkg::addr a, input residuPkg::word d);
		hostWriteEn = 1'b1;
		hostAddr = a;
		hostWriteData = d;
		model[a] = d;
		nextCycle();
		hostWriteEn = 1'b0;
	endtask

	// Whole memory through the host read port
	task automatic verifyMemory;
		for (int i = 0; i < MemDepth; i++)
		begin
			hostAddr = residuPkg::addr'(i);
			nextCycle();
			checkWord($sformatf("mem[%0d]", i), hostReadData, model[i]);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic longint clipLong(input longint v);
		if (v > 64'sd2147483647)
			return 64'sd2147483647;
		if (v < -64'sd2147483648)
			return -64'sd2147483648;
		return v;
	endfunction

	// Doubled product where -1 times -1 clips to the top
	function automatic longint fracMult(input residuPkg::word p, input residuPkg::word q);
		return clipLong(2 * longint'(p) * longint'(q));
	endfunction

	task automatic modelFilter(input residuPkg::addr a, x, y, input int lg);
		longint acc;
		residuPkg::word coef;
		residuPkg::word sample;
		for (int i = 0; i < lg; i++)
		begin
			acc = 0;
			for (int j = 0; j <= residuPkg::FilterOrder; j++)
			begin
				coef = model[residuPkg::addr'(a + j)];
				sample = model[residuPkg::addr'(x + i - j)];
				acc = clipLong(acc + fracMult(coef, sample));
			end
			repeat (residuPkg::ShiftCount)
				acc = clipLong(acc * 2);
			acc = clipLong(acc + 32768);
			model[residuPkg::addr'(y + i)] = residuPkg::word'(acc >>> 16);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	function automatic residuPkg::word nearFull;
		case ($random(seed) & 3)
			0: return -16'sd32768;
			1: return 16'sd32767;
			2: return residuPkg::word'(-32767 + ($random(seed) & 255));
			default: return residuPkg::word'(32500 + ($random(seed) & 255));
		endcase
	endfunction

	// A below X below Y with wrap at the top of memory
	task automatic pickBases(output residuPkg::addr a, x, y, output int lg);
		a = residuPkg::addr'($random(seed));
		x = a + residuPkg::addr'(21 + ($random(seed) & 15));
		y = x + residuPkg::addr'(41 + ($random(seed) & 15));
		lg = 1 + (($random(seed) & 32'h7FFF_FFFF) % 40);
	endtask

	// Coefficients plus input history and samples
	task automatic loadData(input residuPkg::addr a, x, input int lg, input bit fullScale);
		residuPkg::word v;
		for (int j = 0; j <= residuPkg::FilterOrder; j++)
		begin
			v = fullScale ? nearFull() : residuPkg::word'($random(seed));
			hostWrite(residuPkg::addr'(a + j), v);
		end
		for (int i = -residuPkg::FilterOrder; i < lg; i++)
		begin
			v = fullScale ? nearFull() : residuPkg::word'($random(seed) % 4096);
			hostWrite(residuPkg::addr'(x + i), v);
		end
		if (fullScale)
		begin
			hostWrite(a, -16'sd32768);
			hostWrite(x, -16'sd32768);
		end
	endtask

	task automatic runFilter(input residuPkg::addr a, x, y, input int lg, input bit pokeHost);
		int cycles;
		baseA = a;
		baseX = x;
		baseY = y;
		count = lg[residuPkg::CountWidth-1:0];
		start = 1'b1;
		nextCycle();
		start = 1'b0;
		checkFlag("busy after start", busy, 1'b1);
		cycles = 0;
		while (!done)
		begin
			checkFlag("busy while running", busy, 1'b1);
			// Host writes into the source regions that must be ignored
			if (pokeHost)
			begin
				hostWriteEn = 1'b1;
				hostAddr = residuPkg::addr'(((cycles & 1) ? x : a) + cycles % 11);
				hostWriteData = residuPkg::word'($random(seed));
			end
			nextCycle();
			cycles++;
			if (cycles > WaitLimit)
			begin
				$display("Timed out after %0d cycles waiting for done", cycles);
				$display("Verification failed");
				$finish;
			end
		end
		hostWriteEn = 1'b0;
		nextCycle();
		checkFlag("busy after done", busy, 1'b0);
		repeat (3)
		begin
			nextCycle();
			checkFlag("done after its pulse", done, 1'b0);
		end
	endtask

	task automatic finishTest(input string name);
		testCount++;
		$display("Test %-18s finished with %0d errors", name, errorCount - errorsAtStart);
		errorsAtStart = errorCount;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		residuPkg::addr a, x, y;
		int lg;
		int holdCycles;

		reset = 1'b1;
		start = 1'b0;
		baseA = '0;
		baseX = '0;
		baseY = '0;
		count = '0;
		hostWriteEn = 1'b0;
		hostAddr = '0;
		hostWriteData = '0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		checkFlag("done after reset", done, 1'b0);
		checkFlag("busy after reset", busy, 1'b0);

		// Known contents everywhere
		for (int i = 0; i < MemDepth; i++)
			hostWrite(residuPkg::addr'(i), residuPkg::word'((i * 40503) ^ (i >> 3) ^ 16'h5A3C));
		errorsAtStart = errorCount;

		repeat (12)
		begin
			pickBases(a, x, y, lg);
			loadData(a, x, lg, 1'b0);
			runFilter(a, x, y, lg, 1'b0);
			modelFilter(a, x, y, lg);
			verifyMemory();
		end
		finishTest("random runs");

		repeat (4)
		begin
			pickBases(a, x, y, lg);
			loadData(a, x, lg, 1'b1);
			runFilter(a, x, y, lg, 1'b0);
			modelFilter(a, x, y, lg);
			verifyMemory();
		end
		finishTest("saturation");

		pickBases(a, x, y, lg);
		runFilter(a, x, y, 0, 1'b0);
		verifyMemory();
		finishTest("zero length");

		pickBases(a, x, y, lg);
		loadData(a, x, lg, 1'b0);
		runFilter(a, x, y, lg, 1'b1);
		modelFilter(a, x, y, lg);
		verifyMemory();
		finishTest("busy host writes");

		// Abort well before the run can finish
		pickBases(a, x, y, lg);
		lg = 10 + (lg % 31);
		loadData(a, x, lg, 1'b0);
		baseA = a;
		baseX = x;
		baseY = y;
		count = lg[residuPkg::CountWidth-1:0];
		start = 1'b1;
		nextCycle();
		start = 1'b0;
		holdCycles = 20 + ($random(seed) & 127);
		repeat (holdCycles)
		begin
			nextCycle();
			checkFlag("done before reset", done, 1'b0);
		end
		reset = 1'b1;
		nextCycle();
		nextCycle();
		reset = 1'b0;
		// Quiet for longer than the aborted run would have lasted
		repeat (lg * 40)
		begin
			checkFlag("done after mid-run reset", done, 1'b0);
			checkFlag("busy after mid-run reset", busy, 1'b0);
			nextCycle();
		end
		runFilter(a, x, y, lg, 1'b0);
		modelFilter(a, x, y, lg);
		verifyMemory();
		finishTest("mid-run reset");

		$display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- tb.f
verilog/residuPkg.sv
verilog/scratchRam.sv
verilog/macUnit.sv
verilog/longShifter.sv
verilog/residuFsm.sv
verilog/residuTop.sv
verification/residuTb.sv
